// File: logic/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register file.
`define REG_LEN      32
`define REG_ADDR_LEN 5

// ROB tags. The all-ones tag is held back to mark an empty map entry.
`define ROB_TAG_LEN  4
`define ROB_DEPTH    15
`define NO_TAG       ({`ROB_TAG_LEN{1'b1}})

// Wishbone register block.
`define CSR_ADR_LEN  4

`endif

// File: logic/isa_pkg.sv
`default_nettype none

`include "rename_config.svh"

package isa_pkg;

    // Major opcodes as used by RISC-V.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef struct packed {
        logic [6:0]               funct7;
        logic [`REG_ADDR_LEN-1:0] rs2;
        logic [`REG_ADDR_LEN-1:0] rs1;
        logic [2:0]               funct3;
        logic [`REG_ADDR_LEN-1:0] rd;
        opcode_e                  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]              imm12;
        logic [`REG_ADDR_LEN-1:0] rs1;
        logic [2:0]               funct3;
        logic [`REG_ADDR_LEN-1:0] rd;
        opcode_e                  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]               imm_hi;
        logic [`REG_ADDR_LEN-1:0] rs2;
        logic [`REG_ADDR_LEN-1:0] rs1;
        logic [2:0]               funct3;
        logic [4:0]               imm_lo;
        opcode_e                  opcode;
    } s_fmt_t;

    // One instruction word, seen in whichever format its opcode selects.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_u;

endpackage

`default_nettype wire

// File: logic/rename_pkg.sv
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    // Where a source operand can be found at rename time.
    // Bit 1 says the value lives in the ROB and bit 0 says it has been produced.
    typedef enum logic [1:0] {
        IN_REGFILE   = 2'b00,
        PENDING      = 2'b10,
        READY_IN_ROB = 2'b11
    } src_stat_e;

    // One map table entry per architectural register.
    // An entry that holds NO_TAG points at the register file.
    typedef struct packed {
        logic [`ROB_TAG_LEN-1:0] rob_tag;
        logic                    ready_in_rob;
    } map_entry_t;

endpackage

`default_nettype wire

// File: logic/inst_decode.sv
`default_nettype none
`timescale 1ns/100ps

`include "rename_config.svh"

module inst_decode (
    input  isa_pkg::inst_u            inst,
    output logic [`REG_ADDR_LEN-1:0] src1_reg,
    output logic [`REG_ADDR_LEN-1:0] src2_reg,
    output logic [`REG_ADDR_LEN-1:0] dest_reg,
    output logic                      writes_dest
);

    logic has_dest;

    always_comb begin
        src1_reg = '0;
        src2_reg = '0;
        dest_reg = '0;
        has_dest = 1'b0;

        case (inst.r_fmt.opcode)
            isa_pkg::OP: begin
                src1_reg = inst.r_fmt.rs1;
                src2_reg = inst.r_fmt.rs2;
                dest_reg = inst.r_fmt.rd;
                has_dest = 1'b1;
            end
            isa_pkg::OP_IMM, isa_pkg::LOAD: begin
                src1_reg = inst.i_fmt.rs1;
                dest_reg = inst.i_fmt.rd;
                has_dest = 1'b1;
            end
            isa_pkg::STORE: begin
                src1_reg = inst.s_fmt.rs1;
                src2_reg = inst.s_fmt.rs2;
            end
            default: begin
                // Unknown opcodes read and write nothing.
            end
        endcase
    end

    // Register 0 is hardwired, so it is never renamed.
    assign writes_dest = has_dest && (dest_reg != '0);

endmodule

`default_nettype wire

// File: logic/rob_tag_alloc.sv
`default_nettype none
`timescale 1ns/100ps

`include "rename_config.svh"

module rob_tag_alloc (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     alloc,
    input  logic                     free,
    output logic [`ROB_TAG_LEN-1:0] tail_tag,
    output logic [`ROB_TAG_LEN-1:0] head_tag,
    output logic [`ROB_TAG_LEN-1:0] occupancy,
    output logic                     full
);

    logic do_alloc;
    logic do_free;

    // Pointers wrap before the all-ones value, so NO_TAG is never handed out.
    function automatic logic [`ROB_TAG_LEN-1:0] next_ptr(input logic [`ROB_TAG_LEN-1:0] ptr);
        if (ptr == `ROB_TAG_LEN'(`ROB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (occupancy == `ROB_TAG_LEN'(`ROB_DEPTH));
    assign do_alloc = alloc && !full;
    assign do_free  = free && (occupancy != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tail_tag  <= '0;
            head_tag  <= '0;
            occupancy <= '0;
        end else begin
            if (do_alloc) begin
                tail_tag <= next_ptr(tail_tag);
            end
            if (do_free) begin
                head_tag <= next_ptr(head_tag);
            end
            case ({do_alloc, do_free})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/map_table.sv
`default_nettype none
`timescale 1ns/100ps

`include "rename_config.svh"

module map_table (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`REG_ADDR_LEN-1:0] src1_reg,
    input  logic [`REG_ADDR_LEN-1:0] src2_reg,
    input  logic [`REG_ADDR_LEN-1:0] dest_reg,
    input  logic                      assign_en,
    input  logic [`ROB_TAG_LEN-1:0]  assign_tag,
    input  logic                      return_en,
    input  logic [`REG_ADDR_LEN-1:0] return_reg,
    input  logic [`ROB_TAG_LEN-1:0]  return_tag,
    input  logic                      ready_en,
    input  logic [`REG_ADDR_LEN-1:0] ready_reg,
    input  logic [`ROB_TAG_LEN-1:0]  ready_tag,
    output rename_pkg::src_stat_e     src1_stat,
    output logic [`ROB_TAG_LEN-1:0]  src1_tag,
    output rename_pkg::src_stat_e     src2_stat,
    output logic [`ROB_TAG_LEN-1:0]  src2_tag
);

    rename_pkg::map_entry_t map_curr [`REG_LEN];
    rename_pkg::map_entry_t map_next [`REG_LEN];

    function automatic rename_pkg::src_stat_e entry_stat(input rename_pkg::map_entry_t entry);
        if (entry.rob_tag == `NO_TAG) begin
            return rename_pkg::IN_REGFILE;
        end
        if (entry.ready_in_rob) begin
            return rename_pkg::READY_IN_ROB;
        end
        return rename_pkg::PENDING;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_LEN; i++) begin
                map_curr[i].rob_tag      <= `NO_TAG;
                map_curr[i].ready_in_rob <= 1'b0;
            end
        end else begin
            map_curr <= map_next;
        end
    end

    // Assign goes first. Return and ready then compare against the old entry,
    // so they only win over a same-cycle assign when the old tag matched.
    always_comb begin
        map_next = map_curr;

        if (assign_en) begin
            map_next[dest_reg].rob_tag      = assign_tag;
            map_next[dest_reg].ready_in_rob = 1'b0;
        end

        if (return_en) begin
            if (map_curr[return_reg].rob_tag == return_tag) begin
                map_next[return_reg].rob_tag      = `NO_TAG;
                map_next[return_reg].ready_in_rob = 1'b0;
            end
        end

        if (ready_en) begin
            if (map_curr[ready_reg].rob_tag == ready_tag) begin
                map_next[ready_reg].ready_in_rob = 1'b1;
            end
        end
    end

    // An entry pointing at the register file already holds NO_TAG,
    // so the stored tag can be passed through as is.
    always_comb begin
        src1_stat = entry_stat(map_curr[src1_reg]);
        src1_tag  = map_curr[src1_reg].rob_tag;
        src2_stat = entry_stat(map_curr[src2_reg]);
        src2_tag  = map_curr[src2_reg].rob_tag;
    end

endmodule

`default_nettype wire

// File: logic/rename_csr.sv
`default_nettype none
`timescale 1ns/100ps

`include "rename_config.svh"

module rename_csr (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`CSR_ADR_LEN-1:0] wb_adr,
    input  logic [31:0]              wb_dat_w,
    output logic [31:0]              wb_dat_r,
    output logic                     wb_ack,
    input  logic                     renamed,
    input  logic [`ROB_TAG_LEN-1:0] occupancy,
    input  logic                     full,
    output logic                     enable
);

    localparam logic [`CSR_ADR_LEN-1:0] ADR_CTRL   = `CSR_ADR_LEN'(4'h0);
    localparam logic [`CSR_ADR_LEN-1:0] ADR_STATUS = `CSR_ADR_LEN'(4'h4);
    localparam logic [`CSR_ADR_LEN-1:0] ADR_COUNT  = `CSR_ADR_LEN'(4'h8);

    logic        access;
    logic        wr_ctrl;
    logic        wr_count;
    logic [15:0] renamed_count;
    logic [31:0] read_data;

    // The access completes on the edge that raises the acknowledge.
    assign access   = wb_cyc && wb_stb && !wb_ack;
    assign wr_ctrl  = access && wb_we && (wb_adr == ADR_CTRL);
    assign wr_count = access && wb_we && (wb_adr == ADR_COUNT);

    always_comb begin
        case (wb_adr)
            ADR_CTRL:   read_data = {31'b0, enable};
            ADR_STATUS: read_data = {{(31 - `ROB_TAG_LEN){1'b0}}, full, occupancy};
            ADR_COUNT:  read_data = {16'b0, renamed_count};
            default:    read_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            enable        <= 1'b0;
            renamed_count <= '0;
        end else begin
            wb_ack <= access;
            if (wr_ctrl) begin
                enable <= wb_dat_w[0];
            end
            // A clear takes priority over a rename in the same cycle.
            if (wr_count) begin
                renamed_count <= '0;
            end else if (renamed && (renamed_count != '1)) begin
                renamed_count <= renamed_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= read_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "rename_config.svh"

module rename_top (
    input  logic                      clk,
    input  logic                      reset,
    input  isa_pkg::inst_u            inst,
    input  logic                      inst_valid,
    output logic                      inst_ready,
    output logic                      out_valid,
    output rename_pkg::src_stat_e     src1_stat,
    output logic [`REG_ADDR_LEN-1:0] src1_reg,
    output logic [`ROB_TAG_LEN-1:0]  src1_tag,
    output rename_pkg::src_stat_e     src2_stat,
    output logic [`REG_ADDR_LEN-1:0] src2_reg,
    output logic [`ROB_TAG_LEN-1:0]  src2_tag,
    output logic [`REG_ADDR_LEN-1:0] dest_reg,
    output logic [`ROB_TAG_LEN-1:0]  dest_tag,
    input  logic                      commit_valid,
    input  logic [`REG_ADDR_LEN-1:0] commit_reg,
    input  logic                      cdb_valid,
    input  logic [`REG_ADDR_LEN-1:0] cdb_reg,
    input  logic [`ROB_TAG_LEN-1:0]  cdb_tag,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [`CSR_ADR_LEN-1:0]  wb_adr,
    input  logic [31:0]               wb_dat_w,
    output logic [31:0]               wb_dat_r,
    output logic                      wb_ack
);

    logic                     accept;
    logic                     writes_dest;
    logic                     enable;
    logic                     full;
    logic                     commit_ok;
    logic [`ROB_TAG_LEN-1:0] head_tag;
    logic [`ROB_TAG_LEN-1:0] occupancy;

    assign inst_ready = enable && !full;
    assign accept     = inst_valid && inst_ready;
    assign out_valid  = accept;

    // A commit against an empty ROB has no head tag to return.
    assign commit_ok = commit_valid && (occupancy != '0);

    inst_decode u_decode (
        .inst        (inst),
        .src1_reg    (src1_reg),
        .src2_reg    (src2_reg),
        .dest_reg    (dest_reg),
        .writes_dest (writes_dest)
    );

    rob_tag_alloc u_alloc (
        .clk       (clk),
        .reset     (reset),
        .alloc     (accept),
        .free      (commit_valid),
        .tail_tag  (dest_tag),
        .head_tag  (head_tag),
        .occupancy (occupancy),
        .full      (full)
    );

    map_table u_map (
        .clk        (clk),
        .reset      (reset),
        .src1_reg   (src1_reg),
        .src2_reg   (src2_reg),
        .dest_reg   (dest_reg),
        .assign_en  (accept && writes_dest),
        .assign_tag (dest_tag),
        .return_en  (commit_ok),
        .return_reg (commit_reg),
        .return_tag (head_tag),
        .ready_en   (cdb_valid),
        .ready_reg  (cdb_reg),
        .ready_tag  (cdb_tag),
        .src1_stat  (src1_stat),
        .src1_tag   (src1_tag),
        .src2_stat  (src2_stat),
        .src2_tag   (src2_tag)
    );

    rename_csr u_csr (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .renamed   (accept),
        .occupancy (occupancy),
        .full      (full),
        .enable    (enable)
    );

endmodule

`default_nettype wire

// File: dv/rename_tb_table.svh
// Columns: instruction, valid, commit, commit_reg, cdb, cdb_reg, cdb_tag,
// then the expected src1 status and tag, src2 status and tag, and dest_tag.
add_row(make_inst(isa_pkg::OP, 1, 2, 3), 1, 0, 0, 0, 0, 0, ST_RF, NT, ST_RF, NT, 0);
add_row(make_inst(isa_pkg::OP, 2, 1, 0), 1, 0, 0, 0, 0, 0, ST_PEND, 0, ST_RF, NT, 1);
add_row(make_inst(isa_pkg::OP_IMM, 1, 1, 0), 1, 0, 0, 0, 0, 0, ST_PEND, 0, ST_RF, NT, 2);
add_row(make_inst(isa_pkg::STORE, 0, 2, 1), 1, 0, 0, 0, 0, 0, ST_PEND, 1, ST_PEND, 2, 3);
add_row(make_inst(isa_pkg::OP, 0, 1, 2), 1, 0, 0, 0, 0, 0, ST_PEND, 2, ST_PEND, 1, 4);
// Register 0 was written above but must still come from the register file.
add_row(make_inst(isa_pkg::OP, 5, 0, 0), 1, 0, 0, 0, 0, 0, ST_RF, NT, ST_RF, NT, 5);
add_row(make_inst(isa_pkg::OP, 0, 1, 2), 0, 0, 0, 1, 1, 2, ST_PEND, 2, ST_PEND, 1, 6);
add_row(make_inst(isa_pkg::OP, 0, 1, 2), 0, 0, 0, 1, 2, 0, ST_RDY, 2, ST_PEND, 1, 6);
add_row(make_inst(isa_pkg::OP, 0, 1, 2), 0, 1, 1, 0, 0, 0, ST_RDY, 2, ST_PEND, 1, 6);
add_row(make_inst(isa_pkg::OP, 0, 1, 2), 0, 1, 2, 0, 0, 0, ST_RDY, 2, ST_PEND, 1, 6);
add_row(make_inst(isa_pkg::OP, 3, 1, 2), 1, 0, 0, 0, 0, 0, ST_RDY, 2, ST_RF, NT, 6);
// Commit of x1 with a matching head tag wins over the same-cycle rename of x1.
add_row(make_inst(isa_pkg::OP, 1, 3, 1), 1, 1, 1, 0, 0, 0, ST_PEND, 6, ST_RDY, 2, 7);
add_row(make_inst(isa_pkg::OP, 4, 1, 3), 1, 0, 0, 0, 0, 0, ST_RF, NT, ST_PEND, 6, 8);
add_row(make_inst(isa_pkg::OP, 0, 3, 4), 0, 0, 0, 1, 3, 6, ST_PEND, 6, ST_PEND, 8, 9);
add_row(make_inst(isa_pkg::OP, 0, 3, 4), 0, 0, 0, 0, 0, 0, ST_RDY, 6, ST_PEND, 8, 9);
add_row(make_inst(isa_pkg::LOAD, 6, 4, 0), 1, 0, 0, 0, 0, 0, ST_PEND, 8, ST_RF, NT, 9);

// File: dv/rename_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "rename_config.svh"

module rename_tb;

    localparam logic [1:0] ST_RF = rename_pkg::IN_REGFILE;
    localparam logic [1:0] ST_PEND = rename_pkg::PENDING;
    localparam logic [1:0] ST_RDY = rename_pkg::READY_IN_ROB;
    localparam logic [`ROB_TAG_LEN-1:0] NT = `NO_TAG;
    localparam int WB_TIMEOUT = 20;

    typedef struct packed {
        logic [31:0]              inst;
        logic                     valid;
        logic                     commit;
        logic [`REG_ADDR_LEN-1:0] commit_reg;
        logic                     cdb;
        logic [`REG_ADDR_LEN-1:0] cdb_reg;
        logic [`ROB_TAG_LEN-1:0]  cdb_tag;
        logic [1:0]               s1_stat;
        logic [`ROB_TAG_LEN-1:0]  s1_tag;
        logic [1:0]               s2_stat;
        logic [`ROB_TAG_LEN-1:0]  s2_tag;
        logic [`ROB_TAG_LEN-1:0]  dest_tag;
    } row_t;

    logic clk, reset, inst_valid, inst_ready, out_valid;
    isa_pkg::inst_u inst;
    rename_pkg::src_stat_e src1_stat, src2_stat;
    logic [`REG_ADDR_LEN-1:0] src1_reg, src2_reg, dest_reg, commit_reg, cdb_reg;
    logic [`ROB_TAG_LEN-1:0] src1_tag, src2_tag, dest_tag, cdb_tag;
    logic commit_valid, cdb_valid, wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`CSR_ADR_LEN-1:0] wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r, rd_data, lfsr_state;

    // Reference model of the map table, the tag allocator and the counter.
    logic [`ROB_TAG_LEN-1:0] m_tag [`REG_LEN];
    logic m_rdy [`REG_LEN];
    logic [`REG_ADDR_LEN-1:0] m_dest [`ROB_DEPTH];
    logic [`ROB_TAG_LEN-1:0] m_head, m_tail, m_occ;
    logic m_enable;
    logic [15:0] m_count;
    row_t rows[$];
    row_t row;

    rename_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_inst(input logic [6:0] op,
                                              input logic [4:0] rd, rs1, rs2);
        isa_pkg::inst_u w;
        w = '0;
        if (op == isa_pkg::STORE) begin
            w.s_fmt.opcode = isa_pkg::opcode_e'(op);
            w.s_fmt.rs1 = rs1;
            w.s_fmt.rs2 = rs2;
            w.s_fmt.imm_lo = rd;
        end else begin
            w.r_fmt.opcode = isa_pkg::opcode_e'(op);
            w.r_fmt.rd = rd;
            w.r_fmt.rs1 = rs1;
            w.r_fmt.rs2 = rs2;
        end
        return w;
    endfunction

    function automatic void add_row(input logic [31:0] w, input logic v, c,
                                    input logic [4:0] creg, input logic b, input logic [4:0] breg,
                                    input logic [3:0] btag, input logic [1:0] s1s,
                                    input logic [3:0] s1t, input logic [1:0] s2s,
                                    input logic [3:0] s2t, input logic [3:0] dt);
        rows.push_back({w, v, c, creg, b, breg, btag, s1s, s1t, s2s, s2t, dt});
    endfunction

    task automatic load_table();
        `include "rename_tb_table.svh"
    endtask

    task automatic model_decode(input logic [31:0] w, output logic [4:0] s1, s2, d);
        s1 = '0;
        s2 = '0;
        d = '0;
        case (w[6:0])
            isa_pkg::OP: begin
                s1 = w[19:15];
                s2 = w[24:20];
                d = w[11:7];
            end
            isa_pkg::OP_IMM, isa_pkg::LOAD: begin
                s1 = w[19:15];
                d = w[11:7];
            end
            isa_pkg::STORE: begin
                s1 = w[19:15];
                s2 = w[24:20];
            end
            default: ;
        endcase
    endtask

    function automatic logic [1:0] model_stat(input logic [4:0] r);
        if (m_tag[r] == NT) return ST_RF;
        return m_rdy[r] ? ST_RDY : ST_PEND;
    endfunction

    function automatic logic [3:0] next_tag(input logic [3:0] t);
        return (t == `ROB_DEPTH - 1) ? 4'd0 : t + 4'd1;
    endfunction

    task automatic set_expected(inout row_t r);
        logic [4:0] s1, s2, d;
        model_decode(r.inst, s1, s2, d);
        r.s1_stat = model_stat(s1);
        r.s1_tag = m_tag[s1];
        r.s2_stat = model_stat(s2);
        r.s2_tag = m_tag[s2];
        r.dest_tag = m_tail;
    endtask

    // Return and ready are judged on the map as it was before the edge.
    task automatic model_step(input row_t r);
        logic [4:0] s1, s2, d;
        logic acc, fr, ret, rdy;
        model_decode(r.inst, s1, s2, d);
        acc = r.valid && m_enable && (m_occ != `ROB_DEPTH);
        fr = r.commit && (m_occ != 0);
        ret = fr && (m_tag[r.commit_reg] == m_head);
        rdy = r.cdb && (m_tag[r.cdb_reg] == r.cdb_tag);
        if (acc) begin
            if (d != 0) begin
                m_tag[d] = m_tail;
                m_rdy[d] = 1'b0;
            end
            m_dest[m_tail] = d;
            m_tail = next_tag(m_tail);
            if (m_count != 16'hffff) m_count++;
        end
        if (ret) begin
            m_tag[r.commit_reg] = NT;
            m_rdy[r.commit_reg] = 1'b0;
        end
        if (rdy) m_rdy[r.cdb_reg] = 1'b1;
        if (fr) m_head = next_tag(m_head);
        m_occ = m_occ + acc - fr;
    endtask

    task automatic make_random_row(output row_t r);
        logic [6:0] op;
        r = '0;
        r.valid = (rand_bits(2) != 0);
        case (rand_bits(3))
            0, 1: op = isa_pkg::OP;
            2: op = isa_pkg::OP_IMM;
            3: op = isa_pkg::LOAD;
            4, 5: op = isa_pkg::STORE;
            default: op = 7'h73;
        endcase
        r.inst = make_inst(op, rand_bits(3), rand_bits(3), rand_bits(3));
        r.commit = rand_bits(1);
        // Usually commit the register that the head instruction renamed.
        if (rand_bits(1)) r.commit_reg = m_dest[m_head];
        else r.commit_reg = rand_bits(3);
        r.cdb = rand_bits(1);
        r.cdb_reg = rand_bits(3);
        if (rand_bits(1)) r.cdb_tag = m_tag[r.cdb_reg];
        else r.cdb_tag = rand_bits(4);
        set_expected(r);
    endtask

    task automatic apply_row(input row_t r);
        logic exp_ready;
        logic [4:0] s1, s2, d;
        @(negedge clk);
        inst = r.inst;
        inst_valid = r.valid;
        commit_valid = r.commit;
        commit_reg = r.commit_reg;
        cdb_valid = r.cdb;
        cdb_reg = r.cdb_reg;
        cdb_tag = r.cdb_tag;
        #1;
        model_decode(r.inst, s1, s2, d);
        exp_ready = m_enable && (m_occ != `ROB_DEPTH);
        check("inst_ready", inst_ready, exp_ready);
        check("out_valid", out_valid, r.valid && exp_ready);
        check("src1_reg", src1_reg, s1);
        check("src2_reg", src2_reg, s2);
        check("dest_reg", dest_reg, d);
        check("src1_stat", src1_stat, r.s1_stat);
        check("src1_tag", src1_tag, r.s1_tag);
        check("src2_stat", src2_stat, r.s2_stat);
        check("src2_tag", src2_tag, r.s2_tag);
        check("dest_tag", dest_tag, r.dest_tag);
        model_step(r);
    endtask

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat);
        int waited;
        @(negedge clk);
        inst_valid = 1'b0;
        commit_valid = 1'b0;
        cdb_valid = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        waited = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (waited == WB_TIMEOUT) begin
                $display("Wishbone access to address %h was never acknowledged", adr);
                stop_on_failure();
            end
            waited++;
            @(negedge clk);
        end
        rd_data = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read_check(input logic [3:0] adr, input logic [31:0] exp, input string name);
        wb_access(1'b0, adr, 32'h0);
        check(name, rd_data, exp);
    endtask

    initial begin
        reset = 1'b1;
        inst = '0;
        {inst_valid, commit_valid, commit_reg, cdb_valid, cdb_reg, cdb_tag} = '0;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
        lfsr_state = 32'hb286;
        for (int i = 0; i < `REG_LEN; i++) begin
            m_tag[i] = NT;
            m_rdy[i] = 1'b0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) m_dest[i] = '0;
        {m_head, m_tail, m_occ, m_enable, m_count} = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check("inst_ready", inst_ready, 1'b0);
        check("out_valid", out_valid, 1'b0);
        check("wb_ack", wb_ack, 1'b0);
        wb_read_check(4'h0, 32'h0, "ctrl");
        wb_read_check(4'h4, 32'h0, "status");

        // While disabled, a valid instruction must be held back.
        // Its destination is read by the first table row.
        row = '0;
        row.valid = 1'b1;
        row.inst = make_inst(isa_pkg::OP, 2, 1, 3);
        set_expected(row);
        apply_row(row);
        wb_read_check(4'h8, 32'h0, "count");

        wb_access(1'b1, 4'h0, 32'h1);
        m_enable = 1'b1;
        wb_read_check(4'h0, 32'h1, "ctrl");

        load_table();
        foreach (rows[i]) apply_row(rows[i]);

        repeat (200) begin
            make_random_row(row);
            apply_row(row);
        end

        // Rename without commit until the ROB is full, then try twice more.
        for (int n = 0; n < 20 && m_occ != `ROB_DEPTH; n++) begin
            row = '0;
            row.valid = 1'b1;
            row.inst = make_inst(isa_pkg::OP, rand_bits(3), rand_bits(3), rand_bits(3));
            set_expected(row);
            apply_row(row);
        end
        row = '0;
        row.valid = 1'b1;
        row.inst = make_inst(isa_pkg::OP, 7, 7, 2);
        repeat (2) begin
            set_expected(row);
            apply_row(row);
        end
        wb_read_check(4'h4, 32'h1f, "status");

        wb_read_check(4'h8, {16'h0, m_count}, "count");
        wb_access(1'b1, 4'h8, 32'h1234);
        wb_read_check(4'h8, 32'h0, "count");

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
+incdir+dv
logic/isa_pkg.sv
logic/rename_pkg.sv
logic/inst_decode.sv
logic/rob_tag_alloc.sv
logic/map_table.sv
logic/rename_csr.sv
logic/rename_top.sv
dv/rename_tb.sv

// File: Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/rename_pkg.sv
      - logic/inst_decode.sv
      - logic/rob_tag_alloc.sv
      - logic/map_table.sv
      - logic/rename_csr.sv
      - logic/rename_top.sv
  - target: test
    include_dirs:
      - logic
      - dv
    files:
      - dv/rename_tb.sv
